/* packet_buffer.sv */
// Input packet buffer
`timescale 1ns/1ps
`default_nettype none

module packet_buffer import ts_pkg::*; (
  input  wire logic clk,
  input  wire logic reset,
  input  axis_beat_t in_beat,           // Incoming stream beat
  input  wire logic  in_valid,          // Source offers in_beat
  output logic       in_ready,          // Buffer takes in_beat this cycle
  input  wire logic  stamp_nearly_full, // Stamp FIFO cannot take another packet
  output logic       pkt_start,         // First beat of a packet accepted now
  output axis_beat_t data_beat,         // Oldest buffered beat
  output logic       data_empty,        // Nothing buffered
  input  wire logic  data_pop           // Merge consumes data_beat
);

  logic in_pkt;            // Between an accepted first beat and its last beat
  logic fifo_nearly_full;  // One slot left in the beat FIFO
  logic accept;            // Handshake completes this cycle

  // ************************************************************
  // Flow control
  // ************************************************************

  // A new packet only starts when its stamp has somewhere to go
  assign in_ready  = !fifo_nearly_full && (in_pkt || !stamp_nearly_full);
  assign accept    = in_valid && in_ready;
  assign pkt_start = accept && !in_pkt;   // Outside a packet every beat is a first beat

  // Packet tracking
  always_ff @(posedge clk) begin
    if (reset) begin
      in_pkt <= 1'b0;
    end else if (accept) begin
      in_pkt <= !in_beat.tlast;           // A last beat closes the packet
    end
  end

  // ************************************************************
  // Beat queue
  // ************************************************************

  small_fifo #(
    .entry_t    (axis_beat_t),
    .DEPTH_BITS (DATA_DEPTH_BITS)
  ) beat_fifo (
    .clk         (clk),
    .reset       (reset),
    .din         (in_beat),
    .wr_en       (accept),                // Only handshaken beats are stored
    .rd_en       (data_pop),
    .dout        (data_beat),
    .empty       (data_empty),
    .nearly_full (fifo_nearly_full)
  );

endmodule

`default_nettype wire

/* small_fifo.sv */
// Fall-through FIFO
`timescale 1ns/1ps
`default_nettype none

module small_fifo #(
  parameter type entry_t    = logic [7:0],  // Stored item, set per instance
  parameter int  DEPTH_BITS = 2             // Log2 of the number of entries
) (
  input  wire logic clk,
  input  wire logic reset,
  input  entry_t    din,          // Entry to store
  input  wire logic wr_en,        // Push din at the next edge
  input  wire logic rd_en,        // Drop the head entry at the next edge
  output entry_t    dout,         // Head entry while empty is low
  output logic      empty,        // No entries stored
  output logic      nearly_full   // At most one free slot left
);

  // ************************************************************
  // Storage and pointers
  // ************************************************************

  entry_t mem [2**DEPTH_BITS];                   // Circular entry store

  logic [DEPTH_BITS-1:0] wr_ptr;                 // Next slot to write
  logic [DEPTH_BITS-1:0] rd_ptr;                 // Slot holding the head entry
  logic [DEPTH_BITS:0]   count;                  // Number of stored entries
  logic                  full;                   // Every slot occupied
  logic                  do_write;               // Push actually happens
  logic                  do_read;                // Pop actually happens

  // Count never exceeds the depth, so the top bit alone means full
  assign full  = count[DEPTH_BITS];
  assign empty = (count == '0);

  // Low bits all ones is depth minus one entries
  assign nearly_full = full || (&count[DEPTH_BITS-1:0]);

  assign do_write = wr_en && !full;              // Overflowing pushes are ignored
  assign do_read  = rd_en && !empty;             // Popping an empty FIFO does nothing

  // Head shows without a read cycle
  assign dout = mem[rd_ptr];

  // ************************************************************
  // Entry store
  // ************************************************************

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr] <= din;                        // Store the pushed entry
    end
  end

  // ************************************************************
  // Pointer and occupancy control
  // ************************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= wr_ptr + 1'b1;                 // Wraps at the depth
      end
      if (do_read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;          // Push only
        2'b01:   count <= count - 1'b1;          // Pop only
        default: count <= count;                 // Both or neither keeps the level
      endcase
    end
  end

endmodule

`default_nettype wire

/* stamp_unit.sv */
// Stamp counter and queue
`timescale 1ns/1ps
`default_nettype none

module stamp_unit import ts_pkg::*; (
  input  wire logic clk,
  input  wire logic reset,
  input  wire logic pkt_start,          // A packet's first beat is accepted now
  output stamp_t    stamp,              // Stamp of the oldest unmatched packet
  output logic      stamp_empty,        // No stamp waiting
  output logic      stamp_nearly_full,  // Room for only one more stamp
  input  wire logic stamp_pop           // Merge consumes the head stamp
);

  stamp_t counter;  // Free-running time base

  // ************************************************************
  // Time base
  // ************************************************************

  // Reads zero in the first cycle after reset is released
  always_ff @(posedge clk) begin
    if (reset) begin
      counter <= '0;
    end else begin
      counter <= counter + stamp_t'(STAMP_STEP);  // Wraps silently after 2**64 steps
    end
  end

  // ************************************************************
  // Stamp queue
  // ************************************************************

  // The pushed value is the count of the acceptance cycle itself
  small_fifo #(
    .entry_t    (stamp_t),
    .DEPTH_BITS (STAMP_DEPTH_BITS)
  ) stamp_fifo (
    .clk         (clk),
    .reset       (reset),
    .din         (counter),
    .wr_en       (pkt_start),
    .rd_en       (stamp_pop),
    .dout        (stamp),
    .empty       (stamp_empty),
    .nearly_full (stamp_nearly_full)  // Fed back to hold off new packets
  );

endmodule

`default_nettype wire

/* tb_ts_insert.sv */
// Timestamp insertion testbench
`timescale 1ns/1ps
`default_nettype none

module tb_ts_insert import ts_pkg::*; ();

  // ************************************************************
  // DUT signals and testbench state
  // ************************************************************

  logic       clk;
  logic       reset;
  axis_beat_t in_beat;
  logic       in_valid;
  logic       in_ready;
  axis_beat_t out_beat;
  logic       out_valid;
  logic       out_ready;

  typedef enum {READY_RANDOM, READY_LOW, READY_HIGH} ready_mode_t;

  ready_mode_t      ready_mode;      // How the sink drives out_ready
  ready_mode_t      edge_mode;       // Mode in force at the last rising edge
  integer           stim_seed;       // Packet lengths, payloads and gaps
  integer           ready_seed;      // Sink back-pressure pattern
  axis_beat_t       expected_q[$];   // Accepted beats not yet seen at the output
  axis_beat_t       exp_beat;        // Beat being queued by the model
  axis_beat_t       head_beat;       // Oldest expected beat
  axis_beat_t       held_beat;       // Beat stalled at the previous sample
  logic             held_valid;      // A stalled beat must still be present
  logic             in_pkt_model;    // Model of the input packet boundary
  logic [63:0]      cycle_count;     // Zero in the first cycle out of reset
  int unsigned      accepted;        // One-beat packets taken during the stall burst
  int unsigned      wait_cycles;
  logic             blocked;

  ts_insert_top DUT (
    .clk       (clk),
    .reset     (reset),
    .in_beat   (in_beat),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  always begin
    clk = 1'b0;
    #5;
    clk = 1'b1;
    #5;
  end

  // ************************************************************
  // Failure reporting
  // ************************************************************

  task automatic stop_with_failure(input string reason);
    $display("%s at time %0t", reason, $time);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic value_mismatch(input string name, input logic [255:0] got,
                                input logic [255:0] exp);
    $display("FAIL time=%0t %s got %0h expected %0h", $time, name, got, exp);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  // Compares tdata, tstrb, tuser and tlast of one taken beat
  task automatic check_beat(input axis_beat_t got, input axis_beat_t exp);
    assert (got.tdata == exp.tdata) else value_mismatch("out_beat.tdata", got.tdata, exp.tdata);
    assert (got.tstrb == exp.tstrb) else value_mismatch("out_beat.tstrb", got.tstrb, exp.tstrb);
    assert (got.tuser == exp.tuser) else value_mismatch("out_beat.tuser", got.tuser, exp.tuser);
    assert (got.tlast == exp.tlast) else value_mismatch("out_beat.tlast", got.tlast, exp.tlast);
  endtask

  // ************************************************************
  // Reference model and output checks, sampled mid-cycle
  // ************************************************************

  always @(negedge clk) begin
    if (reset) begin
      cycle_count  = '1;                       // Wraps to zero on the first free cycle
      in_pkt_model = 1'b0;
      held_valid   = 1'b0;
    end else begin
      cycle_count = cycle_count + 1;
      if (held_valid) begin                    // Stalled beat must not move or vanish
        assert (out_valid) else stop_with_failure("out_valid fell before the beat was taken");
        assert (out_beat == held_beat) else value_mismatch("out_beat (stalled)", out_beat,
                                                           held_beat);
      end
      if (out_valid && out_ready) begin
        assert (expected_q.size() > 0) else stop_with_failure("Output beat with no input pending");
        head_beat = expected_q.pop_front();
        check_beat(out_beat, head_beat);
      end
      held_valid = out_valid && !out_ready;
      held_beat  = out_beat;
      if (in_valid && in_ready) begin
        exp_beat = in_beat;
        if (!in_pkt_model) begin               // First beat carries the acceptance count
          exp_beat.tuser[STAMP_POS +: STAMP_WIDTH] = stamp_t'(cycle_count * STAMP_STEP);
        end
        expected_q.push_back(exp_beat);
        in_pkt_model = !in_beat.tlast;
      end
    end
  end

  // ************************************************************
  // Sink back-pressure
  // ************************************************************

  always begin
    @(posedge clk);
    edge_mode = ready_mode;                    // Mode changes land after the edge
    #1;
    case (edge_mode)
      READY_RANDOM: out_ready = (($random(ready_seed) & 3) != 0);  // Ready about 3 in 4
      READY_LOW:    out_ready = 1'b0;
      default:      out_ready = 1'b1;
    endcase
  end

  // ************************************************************
  // Stimulus helpers
  // ************************************************************

  function automatic axis_beat_t random_beat(input logic last);
    axis_beat_t beat;
    beat.tdata = {$random(stim_seed), $random(stim_seed)};
    beat.tstrb = $random(stim_seed);
    beat.tuser = {$random(stim_seed), $random(stim_seed), $random(stim_seed), $random(stim_seed)};
    beat.tlast = last;
    return beat;
  endfunction

  // Holds each beat until in_ready was seen high before a rising edge
  task automatic send_packet(input int unsigned len, input int unsigned gap);
    int unsigned tries;
    logic        taken;
    for (int unsigned i = 0; i < len; i++) begin
      in_beat  = random_beat(i == len - 1);
      in_valid = 1'b1;
      taken    = 1'b0;
      tries    = 0;
      while (!taken) begin
        @(negedge clk);
        taken = in_ready;
        @(posedge clk);
        #1;
        tries++;
        if (!taken && tries > 200) begin
          stop_with_failure("Input beat not accepted within 200 cycles");
        end
      end
    end
    in_valid = 1'b0;
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic send_random_packets(input int unsigned count);
    repeat (count) begin
      send_packet(({$random(stim_seed)} % 8) + 1, {$random(stim_seed)} % 4);
    end
  endtask

  // Returns when the model queue is empty or the limit runs out
  task automatic drain_outputs(input int unsigned max_cycles);
    int unsigned n;
    n = 0;
    while (expected_q.size() > 0 && n < max_cycles) begin
      @(posedge clk);
      #1;
      n++;
    end
  endtask

  // ************************************************************
  // Test sequence
  // ************************************************************

  initial begin : main_sequence
    stim_seed  = 32'h8c6c_921a;
    ready_seed = 32'h8c6c_921a;
    ready_mode = READY_HIGH;
    reset      = 1'b1;
    in_valid   = 1'b0;
    in_beat    = '0;
    out_ready  = 1'b0;

    repeat (9) @(posedge clk);
    @(negedge clk);                                // Reset state check while still held
    assert (!out_valid) else value_mismatch("out_valid", out_valid, 1'b0);
    assert (in_ready) else value_mismatch("in_ready", in_ready, 1'b1);
    @(posedge clk);
    #1;
    reset = 1'b0;

    send_random_packets(10);                       // Free-flowing output
    ready_mode = READY_RANDOM;
    send_random_packets(30);                       // Random back-pressure

    ready_mode = READY_HIGH;                       // Empty the pipeline before the stall burst
    drain_outputs(500);
    if (expected_q.size() > 0) begin
      stop_with_failure("Pipeline did not drain before the stall burst");
    end
    ready_mode = READY_LOW;
    repeat (3) begin
      @(posedge clk);
      #1;
    end

    // One-beat packets until the stamp queue stops the input
    accepted    = 0;
    blocked     = 1'b0;
    wait_cycles = 0;
    while (!blocked) begin
      in_beat  = random_beat(1'b1);
      in_valid = 1'b1;
      @(negedge clk);
      if (in_ready) begin
        accepted++;
      end else begin
        blocked = 1'b1;
      end
      @(posedge clk);
      #1;
      wait_cycles++;
      if (!blocked && wait_cycles > 20) begin
        stop_with_failure("in_ready stayed high with the output stalled");
      end
    end
    in_valid = 1'b0;
    // One stamp in the output register, the rest fill the stamp FIFO to nearly full
    assert (accepted == 2**STAMP_DEPTH_BITS)
      else value_mismatch("packets accepted before in_ready fell", accepted,
                          2**STAMP_DEPTH_BITS);
    repeat (5) begin
      @(posedge clk);
      #1;
    end

    ready_mode = READY_RANDOM;
    send_random_packets(10);

    ready_mode = READY_HIGH;
    drain_outputs(500);
    repeat (10) begin                              // Catch any extra beat after the drain
      @(posedge clk);
      #1;
    end
    if (expected_q.size() == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("%0d expected beats never came out", expected_q.size());
      stop_with_failure("Drain timed out");
    end
  end

endmodule

`default_nettype wire

/* timestamp_merge.sv */
// Packet and stamp merge
`timescale 1ns/1ps
`default_nettype none

module timestamp_merge import ts_pkg::*; (
  input  wire logic clk,
  input  wire logic reset,
  input  axis_beat_t data_beat,    // Head of the packet FIFO
  input  wire logic  data_empty,   // Packet FIFO has no beat
  output logic       data_pop,     // Take data_beat this cycle
  input  stamp_t     stamp,        // Head of the stamp FIFO
  input  wire logic  stamp_empty,  // Stamp FIFO has no entry
  output logic       stamp_pop,    // Take stamp this cycle
  output axis_beat_t out_beat,     // Registered output beat
  output logic       out_valid,    // out_beat holds a beat
  input  wire logic  out_ready     // Sink takes out_beat this cycle
);

  // Two phases of every packet
  typedef enum logic {
    AWAIT_PACKET,   // Waiting for a first beat and its stamp
    FORWARD         // Passing the remaining beats through
  } state_t;

  state_t     state;       // Current phase
  state_t     state_next;  // Phase after this edge
  axis_beat_t next_beat;   // Beat to load into the output register
  logic       reg_free;    // Output register can take a new beat
  logic       load;        // Output register loads next_beat at this edge

  // ************************************************************
  // Output register availability
  // ************************************************************

  // Empty, or its current beat leaves at this same edge
  assign reg_free = !out_valid || out_ready;

  // ************************************************************
  // Next-beat selection and FIFO pops
  // ************************************************************

  always_comb begin
    next_beat  = data_beat;   // Later beats pass through unchanged
    load       = 1'b0;
    data_pop   = 1'b0;
    stamp_pop  = 1'b0;
    state_next = state;

    case (state)
      AWAIT_PACKET: begin
        // A packet goes out only together with its own stamp
        if (!data_empty && !stamp_empty && reg_free) begin
          next_beat.tuser[STAMP_POS +: STAMP_WIDTH] = stamp;  // Overlay the stamp
          load      = 1'b1;
          data_pop  = 1'b1;
          stamp_pop = 1'b1;
          if (!data_beat.tlast) begin
            state_next = FORWARD;   // One-beat packets are already complete
          end
        end
      end

      FORWARD: begin
        if (!data_empty && reg_free) begin
          load     = 1'b1;
          data_pop = 1'b1;
          if (data_beat.tlast) begin
            state_next = AWAIT_PACKET;   // Next beat in the FIFO starts a packet
          end
        end
      end

      default: begin
        state_next = AWAIT_PACKET;
      end
    endcase
  end

  // ************************************************************
  // State and output valid
  // ************************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= AWAIT_PACKET;
      out_valid <= 1'b0;
    end else begin
      state <= state_next;
      if (load) begin
        out_valid <= 1'b1;          // New beat replaces or fills the register
      end else if (out_ready) begin
        out_valid <= 1'b0;          // Beat taken with nothing behind it
      end
    end
  end

  // Payload only changes on a load, so a stalled beat is held as is
  always_ff @(posedge clk) begin
    if (load) begin
      out_beat <= next_beat;
    end
  end

endmodule

`default_nettype wire

/* ts_insert_top.sv */
// Receive timestamp insertion
`timescale 1ns/1ps
`default_nettype none

module ts_insert_top import ts_pkg::*; (
  input  wire logic  clk,
  input  wire logic  reset,
  input  axis_beat_t in_beat,    // Packet stream from the receive path
  input  wire logic  in_valid,
  output logic       in_ready,
  output axis_beat_t out_beat,   // Same stream with stamps in first-beat sideband
  output logic       out_valid,
  input  wire logic  out_ready
);

  // ************************************************************
  // Internal connections
  // ************************************************************

  logic       pkt_start;          // First-beat acceptance strobe
  logic       stamp_nearly_full;  // Stamp queue back-pressure to the input
  axis_beat_t data_beat;          // Buffered beat toward the merge
  logic       data_empty;
  logic       data_pop;
  stamp_t     stamp;              // Queued stamp toward the merge
  logic       stamp_empty;
  logic       stamp_pop;

  packet_buffer u_packet_buffer (
    .clk               (clk),
    .reset             (reset),
    .in_beat           (in_beat),
    .in_valid          (in_valid),
    .in_ready          (in_ready),
    .stamp_nearly_full (stamp_nearly_full),
    .pkt_start         (pkt_start),
    .data_beat         (data_beat),
    .data_empty        (data_empty),
    .data_pop          (data_pop)
  );

  stamp_unit u_stamp_unit (
    .clk               (clk),
    .reset             (reset),
    .pkt_start         (pkt_start),
    .stamp             (stamp),
    .stamp_empty       (stamp_empty),
    .stamp_nearly_full (stamp_nearly_full),
    .stamp_pop         (stamp_pop)
  );

  timestamp_merge u_timestamp_merge (
    .clk         (clk),
    .reset       (reset),
    .data_beat   (data_beat),
    .data_empty  (data_empty),
    .data_pop    (data_pop),
    .stamp       (stamp),
    .stamp_empty (stamp_empty),
    .stamp_pop   (stamp_pop),
    .out_beat    (out_beat),
    .out_valid   (out_valid),
    .out_ready   (out_ready)
  );

endmodule

`default_nettype wire

/* ts_pkg.sv */
// Timestamp insertion definitions
`default_nettype none

package ts_pkg;

  // ************************************************************
  // Stream geometry
  // ************************************************************

  localparam int DATA_WIDTH = 64;              // Bits carried by one data beat
  localparam int STRB_WIDTH = DATA_WIDTH / 8;  // One strobe bit per data byte
  localparam int USER_WIDTH = 128;             // Sideband travelling with each beat

  // ************************************************************
  // Stamp format and placement
  // ************************************************************

  localparam int STAMP_WIDTH = 64;            // Width of the free-running stamp
  localparam int STAMP_POS   = 32;            // Lowest sideband bit the stamp replaces
  localparam int unsigned STAMP_STEP = 1;     // Counter increment per clock

  // ************************************************************
  // Buffer sizes
  // ************************************************************

  localparam int DATA_DEPTH_BITS  = 4;        // Packet FIFO holds 16 beats
  localparam int STAMP_DEPTH_BITS = 2;        // Stamp FIFO holds 4 stamps

  // Captured counter value for one packet
  typedef logic [STAMP_WIDTH-1:0] stamp_t;

  // One beat of the packet stream with its side signals
  typedef struct packed {
    logic [DATA_WIDTH-1:0] tdata;  // Payload bytes
    logic [STRB_WIDTH-1:0] tstrb;  // Byte qualifiers
    logic [USER_WIDTH-1:0] tuser;  // Sideband that carries the stamp on first beats
    logic                  tlast;  // Marks the final beat of a packet
  } axis_beat_t;

endpackage

`default_nettype wire

/* vlog.f */
ts_pkg.sv
small_fifo.sv
packet_buffer.sv
stamp_unit.sv
timestamp_merge.sv
ts_insert_top.sv
tb_ts_insert.sv
